//--- source/vertex_pkg.sv
`default_nettype none

package vertex_pkg;

    localparam int FRAC_BITS = 16;               // Q16.16
    localparam logic signed [31:0] FIX_ONE = 32'sh0001_0000;

    typedef logic signed [31:0] coord_t;
    typedef logic [7:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        coord_t w;
    } vec4_t;

    typedef vec4_t [3:0] matrix_t;               // Row 0 produces x

    typedef struct packed {
        vec4_t  pos;
        rgb_t   color;
        logic   project;                         // Perspective divide wanted
    } stage_item_t;

    typedef struct packed {
        coord_t origin_x;
        coord_t origin_y;
        coord_t half_width;
        coord_t half_height;
    } viewport_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
        rgb_t   color;
    } window_vertex_t;

    ////////////////////
    // Fixed-point arithmetic

    // Full product, rescaled and kept to one word
    function automatic coord_t fix_mul(input coord_t a, input coord_t b);
        logic signed [63:0] prod;
        prod = a * b;
        return coord_t'(prod >>> FRAC_BITS);
    endfunction

    // Quotient a / b, truncated toward zero; caller keeps b nonzero
    function automatic coord_t fix_div(input coord_t a, input coord_t b);
        logic signed [47:0] num;
        logic signed [47:0] den;
        logic signed [47:0] quot;
        num  = 48'(a);
        num  = num <<< FRAC_BITS;
        den  = 48'(b);
        quot = num / den;
        return coord_t'(quot);
    endfunction

endpackage

`default_nettype wire

//--- source/matrix_store.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_store
(
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              load_row,
    input  wire logic [1:0]        row_index,
    input  wire vertex_pkg::vec4_t row_data,
    input  wire logic              load_identity,
    output vertex_pkg::matrix_t    matrix
);

    import vertex_pkg::*;

    ////////////////////
    // Row register file
    //
    // Identity has priority over a row write in the same cycle.
    // New contents are visible from the next cycle on, so stage 1
    // always sees the matrix from before any load in its input cycle.

    always_ff @(posedge clk)
    begin
        if (reset || load_identity)
        begin
            for (int r = 0; r < 4; r++)
            begin
                matrix[r] <= '0;
            end
            matrix[0].x <= FIX_ONE;    // Diagonal
            matrix[1].y <= FIX_ONE;
            matrix[2].z <= FIX_ONE;
            matrix[3].w <= FIX_ONE;
        end
        else if (load_row)
        begin
            matrix[row_index] <= row_data;
        end
    end

endmodule

`default_nettype wire

//--- source/matrix_vector_mul.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_vector_mul
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    in_valid,
    input  wire vertex_pkg::stage_item_t in_item,
    input  wire vertex_pkg::matrix_t     matrix,
    output logic                         out_valid,
    output vertex_pkg::stage_item_t      out_item
);

    import vertex_pkg::*;

    coord_t dot [4];        // One dot product per matrix row
    vec4_t  product;

    ////////////////////
    // Dot products

    always_comb
    begin
        for (int r = 0; r < 4; r++)
        begin
            // Sum wraps modulo 2^32
            dot[r] = fix_mul(matrix[r].x, in_item.pos.x)
                   + fix_mul(matrix[r].y, in_item.pos.y)
                   + fix_mul(matrix[r].z, in_item.pos.z)
                   + fix_mul(matrix[r].w, in_item.pos.w);
        end
    end

    always_comb
    begin
        product.x = dot[0];
        product.y = dot[1];
        product.z = dot[2];
        product.w = dot[3];
    end

    ////////////////////
    // Stage register

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    // Payload follows the strobe, no reset needed
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            out_item.pos     <= product;
            out_item.color   <= in_item.color;      // Untouched by the transform
            out_item.project <= in_item.project;
        end
    end

endmodule

`default_nettype wire

//--- source/perspective_divide.sv
`timescale 1ns/1ps
`default_nettype none

module perspective_divide
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    in_valid,
    input  wire vertex_pkg::stage_item_t in_item,
    output logic                         out_valid,
    output vertex_pkg::stage_item_t      out_item
);

    import vertex_pkg::*;

    logic  do_divide;
    vec4_t divided;

    // A zero w bypasses the dividers altogether
    assign do_divide = in_item.project && (in_item.pos.w != '0);

    always_comb
    begin
        if (do_divide)
        begin
            divided.x = fix_div(in_item.pos.x, in_item.pos.w);
            divided.y = fix_div(in_item.pos.y, in_item.pos.w);
            divided.z = fix_div(in_item.pos.z, in_item.pos.w);
            divided.w = FIX_ONE;                    // w / w
        end
        else
        begin
            divided = in_item.pos;
        end
    end

    ////////////////////
    // Stage register

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            out_item.pos     <= divided;
            out_item.color   <= in_item.color;
            out_item.project <= in_item.project;
        end
    end

endmodule

`default_nettype wire

//--- source/viewport_map.sv
`timescale 1ns/1ps
`default_nettype none

module viewport_map
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    in_valid,
    input  wire vertex_pkg::stage_item_t in_item,
    input  wire vertex_pkg::viewport_t   viewport,
    output logic                         out_valid,
    output vertex_pkg::window_vertex_t   out_vertex
);

    import vertex_pkg::*;

    coord_t shifted_x;      // x + 1.0, range 0..2 for normalized input
    coord_t shifted_y;
    coord_t win_x;
    coord_t win_y;

    // origin + (n + 1) * half_size
    always_comb
    begin
        shifted_x = in_item.pos.x + FIX_ONE;
        shifted_y = in_item.pos.y + FIX_ONE;
        win_x     = viewport.origin_x + fix_mul(shifted_x, viewport.half_width);
        win_y     = viewport.origin_y + fix_mul(shifted_y, viewport.half_height);
    end

    ////////////////////
    // Output register

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            out_vertex.x     <= win_x;
            out_vertex.y     <= win_y;
            out_vertex.z     <= in_item.pos.z;     // Depth kept as is, w dropped
            out_vertex.color <= in_item.color;
        end
    end

endmodule

`default_nettype wire

//--- source/vertex_transform_top.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_transform_top
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    vertex_valid,
    input  wire vertex_pkg::stage_item_t vertex_in,
    input  wire logic                    load_row,
    input  wire logic [1:0]              row_index,
    input  wire vertex_pkg::vec4_t       row_data,
    input  wire logic                    load_identity,
    input  wire vertex_pkg::viewport_t   viewport,
    output logic                         out_valid,
    output vertex_pkg::window_vertex_t   out_vertex
);

    import vertex_pkg::*;

    matrix_t     matrix;
    logic        mul_valid;         // Stage 1 to stage 2
    stage_item_t mul_item;
    logic        div_valid;         // Stage 2 to stage 3
    stage_item_t div_item;

    matrix_store matrix_store_i (
        .clk           (clk),
        .reset         (reset),
        .load_row      (load_row),
        .row_index     (row_index),
        .row_data      (row_data),
        .load_identity (load_identity),
        .matrix        (matrix)
    );

    matrix_vector_mul matrix_vector_mul_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (vertex_valid),
        .in_item   (vertex_in),
        .matrix    (matrix),
        .out_valid (mul_valid),
        .out_item  (mul_item)
    );

    perspective_divide perspective_divide_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_valid),
        .in_item   (mul_item),
        .out_valid (div_valid),
        .out_item  (div_item)
    );

    viewport_map viewport_map_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (div_valid),
        .in_item    (div_item),
        .viewport   (viewport),
        .out_valid  (out_valid),
        .out_vertex (out_vertex)
    );

endmodule

`default_nettype wire

//--- verification/vertex_transform_assert.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_transform_assert
(
    input wire logic                       clk,
    input wire logic                       reset,
    input wire logic                       vertex_valid,
    input wire vertex_pkg::stage_item_t    vertex_in,
    input wire logic                       load_row,
    input wire logic [1:0]                 row_index,
    input wire vertex_pkg::vec4_t          row_data,
    input wire logic                       load_identity,
    input wire vertex_pkg::viewport_t      viewport,
    input wire logic                       out_valid,
    input wire vertex_pkg::window_vertex_t out_vertex
);

    import vertex_pkg::*;

    matrix_t        ref_matrix;
    window_vertex_t expected_buf [8];       // Results in order of arrival
    logic [2:0]     wr_ptr;
    logic [2:0]     rd_ptr;
    logic [2:0]     valid_hist;             // vertex_valid over the last three cycles
    logic           reset_prev = 1'b0;      // reset as sampled at the previous edge
    logic           error_seen = 1'b0;
    window_vertex_t expected;
    logic           mismatch;
    logic           error_flag;             // Watched by the testbench

    ////////////////////
    // Q16.16 reference arithmetic

    function automatic coord_t fixed_mul(input coord_t a, input coord_t b);
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        logic signed [63:0] prod;
        wide_a = {{32{a[31]}}, a};
        wide_b = {{32{b[31]}}, b};
        prod   = wide_a * wide_b;
        return prod[FRAC_BITS+31:FRAC_BITS];
    endfunction

    function automatic coord_t fixed_div(input coord_t a, input coord_t b);
        logic signed [47:0] num;
        logic signed [47:0] den;
        logic signed [47:0] quot;
        num  = {a, 16'h0000};               // a scaled by 2^16
        den  = {{16{b[31]}}, b};
        quot = num / den;                   // Truncates toward zero
        return quot[31:0];
    endfunction

    function automatic coord_t row_dot(input vec4_t row, input vec4_t p);
        return fixed_mul(row.x, p.x) + fixed_mul(row.y, p.y)
             + fixed_mul(row.z, p.z) + fixed_mul(row.w, p.w);
    endfunction

    function automatic matrix_t identity_matrix();
        matrix_t m;
        m      = '0;
        m[0].x = FIX_ONE;
        m[1].y = FIX_ONE;
        m[2].z = FIX_ONE;
        m[3].w = FIX_ONE;
        return m;
    endfunction

    function automatic window_vertex_t expected_vertex(input stage_item_t item,
                                                       input matrix_t m,
                                                       input viewport_t vp);
        vec4_t          q;
        coord_t         nx;
        coord_t         ny;
        coord_t         nz;
        window_vertex_t v;
        q.x = row_dot(m[0], item.pos);
        q.y = row_dot(m[1], item.pos);
        q.z = row_dot(m[2], item.pos);
        q.w = row_dot(m[3], item.pos);
        if (item.project && q.w != 0)
        begin
            nx = fixed_div(q.x, q.w);
            ny = fixed_div(q.y, q.w);
            nz = fixed_div(q.z, q.w);
        end
        else
        begin
            nx = q.x;
            ny = q.y;
            nz = q.z;
        end
        v.x     = vp.origin_x + fixed_mul(nx + FIX_ONE, vp.half_width);
        v.y     = vp.origin_y + fixed_mul(ny + FIX_ONE, vp.half_height);
        v.z     = nz;
        v.color = item.color;
        return v;
    endfunction

    ////////////////////
    // Reference model

    always @(posedge clk)
    begin
        if (reset)
        begin
            ref_matrix <= identity_matrix();
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            valid_hist <= '0;
        end
        else
        begin
            valid_hist <= {valid_hist[1:0], vertex_valid};
            if (vertex_valid)
            begin
                // Matrix as it stood before any load in this cycle
                expected_buf[wr_ptr] <= expected_vertex(vertex_in, ref_matrix, viewport);
                wr_ptr               <= wr_ptr + 3'd1;
            end
            if (out_valid)
            begin
                rd_ptr <= rd_ptr + 3'd1;
            end
            if (load_identity)
            begin
                ref_matrix <= identity_matrix();    // Wins over a row load
            end
            else if (load_row)
            begin
                ref_matrix[row_index] <= row_data;
            end
        end
        reset_prev <= reset;
        if (mismatch)
        begin
            error_seen <= 1'b1;
        end
    end

    assign expected   = expected_buf[rd_ptr];
    assign mismatch   = (reset && reset_prev && out_valid !== 1'b0)
                     || (!reset && out_valid !== valid_hist[2])
                     || (!reset && out_valid && out_vertex !== expected);
    assign error_flag = error_seen || mismatch;

    ////////////////////
    // Assertions

    reset_quiet: assert property (@(posedge clk) (reset && reset_prev) |-> !out_valid)
        else $error("ERROR %0t out_valid expected 0 got %b", $time, $sampled(out_valid));

    latency: assert property (@(posedge clk) disable iff (reset) out_valid == valid_hist[2])
        else $error("ERROR %0t out_valid expected %b got %b", $time,
                    $sampled(valid_hist[2]), $sampled(out_valid));

    x_value: assert property (@(posedge clk) disable iff (reset)
                              out_valid |-> out_vertex.x == expected.x)
        else $error("ERROR %0t out_vertex.x expected %h got %h", $time,
                    $sampled(expected.x), $sampled(out_vertex.x));

    y_value: assert property (@(posedge clk) disable iff (reset)
                              out_valid |-> out_vertex.y == expected.y)
        else $error("ERROR %0t out_vertex.y expected %h got %h", $time,
                    $sampled(expected.y), $sampled(out_vertex.y));

    z_value: assert property (@(posedge clk) disable iff (reset)
                              out_valid |-> out_vertex.z == expected.z)
        else $error("ERROR %0t out_vertex.z expected %h got %h", $time,
                    $sampled(expected.z), $sampled(out_vertex.z));

    color_value: assert property (@(posedge clk) disable iff (reset)
                                  out_valid |-> out_vertex.color == expected.color)
        else $error("ERROR %0t out_vertex.color expected %h got %h", $time,
                    $sampled(expected.color), $sampled(out_vertex.color));

endmodule

`default_nettype wire

//--- verification/vertex_transform_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_transform_tb;

    import vertex_pkg::*;

    localparam int CYCLE_LIMIT = 3000;     // Stimulus below needs roughly 800

    logic           clk;
    logic           reset;
    logic           vertex_valid;
    stage_item_t    vertex_in;
    logic           load_row;
    logic [1:0]     row_index;
    vec4_t          row_data;
    logic           load_identity;
    viewport_t      viewport;
    logic           out_valid;
    window_vertex_t out_vertex;

    int sent        = 0;
    int received    = 0;
    int cycle_count = 0;

    vertex_transform_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .vertex_valid  (vertex_valid),
        .vertex_in     (vertex_in),
        .load_row      (load_row),
        .row_index     (row_index),
        .row_data      (row_data),
        .load_identity (load_identity),
        .viewport      (viewport),
        .out_valid     (out_valid),
        .out_vertex    (out_vertex)
    );

    bind vertex_transform_top vertex_transform_assert assert_i (
        .clk           (clk),
        .reset         (reset),
        .vertex_valid  (vertex_valid),
        .vertex_in     (vertex_in),
        .load_row      (load_row),
        .row_index     (row_index),
        .row_data      (row_data),
        .load_identity (load_identity),
        .viewport      (viewport),
        .out_valid     (out_valid),
        .out_vertex    (out_vertex)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////
    // Watchdogs

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Test failures found");
            $fatal(1, "Timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    always @(posedge clk)
    begin
        if (dut_i.assert_i.error_flag)
        begin
            $display("Test failures found");
            $fatal(1, "Checker reported an error at the DUT outputs");
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            received <= 0;
        end
        else if (out_valid)
        begin
            received <= received + 1;
        end
    end

    ////////////////////
    // Random values

    function automatic coord_t rand_coord();    // -8.0 .. 8.0
        return coord_t'($urandom_range(32'h0010_0000)) - 32'sh0008_0000;
    endfunction

    function automatic coord_t rand_nonzero_w();
        coord_t mag;
        mag = coord_t'($urandom_range(32'h0008_0000, 32'h0000_4000));    // 0.25 .. 8.0
        return ($urandom_range(1) != 0) ? -mag : mag;
    endfunction

    function automatic vec4_t rand_vec();
        vec4_t v;
        v.x = rand_coord();
        v.y = rand_coord();
        v.z = rand_coord();
        v.w = rand_coord();
        return v;
    endfunction

    function automatic stage_item_t rand_item(input logic project);
        stage_item_t item;
        item.pos         = rand_vec();
        item.color.red   = channel_t'($urandom);
        item.color.green = channel_t'($urandom);
        item.color.blue  = channel_t'($urandom);
        item.project     = project;
        return item;
    endfunction

    function automatic viewport_t rand_viewport();
        viewport_t vp;
        vp.origin_x    = coord_t'($urandom_range(1024) << 16);
        vp.origin_y    = coord_t'($urandom_range(1024) << 16);
        vp.half_width  = coord_t'($urandom_range(512, 16) << 16);
        vp.half_height = coord_t'($urandom_range(512, 16) << 16);
        return vp;
    endfunction

    ////////////////////
    // Drive tasks

    // One clock of inputs, held until the next call
    task automatic drive_cycle(input logic vv, input stage_item_t item, input logic lr,
                               input logic [1:0] idx, input vec4_t data, input logic li);
        @(posedge clk);
        vertex_valid  <= vv;
        vertex_in     <= item;
        load_row      <= lr;
        row_index     <= idx;
        row_data      <= data;
        load_identity <= li;
        if (vv)
        begin
            sent++;
        end
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0, 2'd0, '0, 1'b0);
    endtask

    task automatic drain();
        idle_cycle();
        while (received != sent)
        begin
            idle_cycle();
        end
    endtask

    // Viewport only changes with the pipeline empty
    task automatic set_viewport(input viewport_t vp);
        drain();
        @(posedge clk);
        viewport <= vp;
    endtask

    // Reset in mid stream drops whatever is in flight
    task automatic apply_reset(input int cycles);
        @(posedge clk);
        reset         <= 1'b1;
        vertex_valid  <= 1'b0;
        load_row      <= 1'b0;
        load_identity <= 1'b0;
        repeat (cycles) @(posedge clk);
        reset <= 1'b0;
        sent = 0;
    endtask

    ////////////////////
    // Stimulus

    initial
    begin
        stage_item_t item;
        void'($urandom(32'h7d0e_59d3));
        reset                = 1'b1;
        vertex_valid         = 1'b0;
        vertex_in            = '0;
        load_row             = 1'b0;
        row_index            = 2'd0;
        row_data             = '0;
        load_identity        = 1'b0;
        viewport.origin_x    = 32'sh0140_0000;     // 640 x 480 window
        viewport.origin_y    = 32'sh00F0_0000;
        viewport.half_width  = 32'sh0140_0000;
        viewport.half_height = 32'sh00F0_0000;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (5) idle_cycle();

        // Identity matrix straight after reset
        for (int i = 0; i < 40; i++)
        begin
            drive_cycle(1'b1, rand_item(1'b0), 1'b0, 2'd0, '0, 1'b0);
            repeat ($urandom_range(2)) idle_cycle();
        end

        // Row loads mixed with vertices, some in the same cycle
        for (int round = 0; round < 8; round++)
        begin
            drive_cycle(1'b1, rand_item(1'b0), 1'b1, 2'(round % 4), rand_vec(), 1'b0);
            for (int c = 0; c < 39; c++)
            begin
                drive_cycle($urandom_range(3) != 0, rand_item(1'b0),
                            $urandom_range(7) == 0, 2'($urandom_range(3)), rand_vec(), 1'b0);
            end
        end

        // Reset with vertices in flight and identity again afterwards
        repeat (4) drive_cycle(1'b1, rand_item(1'b0), 1'b0, 2'd0, '0, 1'b0);
        apply_reset(2);
        repeat (10) drive_cycle(1'b1, rand_item(1'b0), 1'b0, 2'd0, '0, 1'b0);

        // Back to identity, then identity and a row load together
        drive_cycle(1'b0, '0, 1'b0, 2'd0, '0, 1'b1);
        repeat (20) drive_cycle(1'b1, rand_item(1'b0), 1'b0, 2'd0, '0, 1'b0);
        drive_cycle(1'b1, rand_item(1'b0), 1'b1, 2'($urandom_range(3)), rand_vec(), 1'b1);
        repeat (10) drive_cycle(1'b1, rand_item(1'b0), 1'b0, 2'd0, '0, 1'b0);

        // Perspective divide, w of zero now and then
        for (int i = 0; i < 120; i++)
        begin
            item = rand_item(1'b1);
            if ($urandom_range(7) == 0)
            begin
                item.pos.w = '0;
            end
            else
            begin
                item.pos.w = rand_nonzero_w();
            end
            drive_cycle(1'b1, item, 1'b0, 2'd0, '0, 1'b0);
            repeat ($urandom_range(1)) idle_cycle();
        end

        // Several viewports with a fresh matrix each
        for (int v = 0; v < 4; v++)
        begin
            set_viewport(rand_viewport());
            for (int r = 0; r < 4; r++)
            begin
                drive_cycle(1'b0, '0, 1'b1, 2'(r), rand_vec(), 1'b0);
            end
            repeat (20) drive_cycle(1'b1, rand_item($urandom_range(1) != 0),
                                    1'b0, 2'd0, '0, 1'b0);
        end

        drain();
        repeat (3) idle_cycle();
        if (dut_i.assert_i.error_flag)
        begin
            $display("Test failures found");
            $fatal(1, "Checker reported an error before the end of the run");
        end
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
source/vertex_pkg.sv
source/matrix_store.sv
source/matrix_vector_mul.sv
source/perspective_divide.sv
source/viewport_map.sv
source/vertex_transform_top.sv
verification/vertex_transform_assert.sv
verification/vertex_transform_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= vertex_transform_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  := sources.f
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
